/* cart_main.f */
snes_pkg.sv
rom_pkg.sv
snes_bus_decode.sv
rom_arbiter.sv
rom_port.sv
cart_main.sv
tb_cart_main.sv

/* cart_main.sv */
`timescale 1ns/1ns
module cart_main
  import snes_pkg::*;
  import rom_pkg::*;
#(
  parameter int dead_timeout = 80000
) (
  input  logic        CLK2,
  input  logic        reset,
  // SNES side
  input  snes_addr_t  snes_addr_in,
  input  logic        snes_read_in,
  input  logic        snes_romsel_in,
  input  logic        snes_cpu_clk_in,
  output snes_byte_t  snes_data_out,
  output logic        snes_databus_oe,   // Active low
  // Mapping
  input  rom_addr_t   rom_mask,
  // MCU side
  input  rom_addr_t   mcu_addr,
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  input  snes_byte_t  mcu_dout,
  output snes_byte_t  mcu_din,
  output logic        mcu_rdy,
  // ROM side
  output logic [22:0] rom_addr,
  output rom_word_t   rom_data_out,
  output logic        rom_data_oe,
  output logic        rom_we,
  output logic        rom_bhe,
  output logic        rom_ble,
  input  rom_word_t   rom_data_in
);

  snes_addr_t snes_addr;
  logic       snes_read;
  logic       rom_hit;
  logic       free_slot;
  logic       snes_dead;
  logic       snes_revive;
  rom_addr_t  mcu_rom_addr;
  logic       mcu_rd_hit;
  logic       mcu_wr_hit;

  //////////////////////////////////////////////////////////////
  // Decode, execute, result
  //////////////////////////////////////////////////////////////

  snes_bus_decode #(
    .dead_timeout (dead_timeout)
  ) u_decode (
    .CLK2            (CLK2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_addr       (snes_addr),
    .snes_read       (snes_read),
    .rom_hit         (rom_hit),
    .cycle_start     (),   // Folded into free_slot
    .cycle_end       (),
    .free_slot       (free_slot),
    .snes_dead       (snes_dead),
    .snes_revive     (snes_revive)
  );

  rom_arbiter u_arbiter (
    .CLK2         (CLK2),
    .reset        (reset),
    .free_slot    (free_slot),
    .snes_dead    (snes_dead),
    .snes_revive  (snes_revive),
    .mcu_addr     (mcu_addr),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .rom_data_in  (rom_data_in),
    .mcu_rom_addr (mcu_rom_addr),
    .mcu_rd_hit   (mcu_rd_hit),
    .mcu_wr_hit   (mcu_wr_hit),
    .mcu_din      (mcu_din),
    .mcu_rdy      (mcu_rdy)
  );

  rom_port u_port (
    .mcu_rd_hit      (mcu_rd_hit),
    .mcu_wr_hit      (mcu_wr_hit),
    .mcu_rom_addr    (mcu_rom_addr),
    .snes_addr       (snes_addr),
    .rom_mask        (rom_mask),
    .rom_hit         (rom_hit),
    .snes_read       (snes_read),
    .mcu_dout        (mcu_dout),
    .rom_data_in     (rom_data_in),
    .rom_addr        (rom_addr),
    .rom_data_out    (rom_data_out),
    .rom_data_oe     (rom_data_oe),
    .rom_we          (rom_we),
    .rom_bhe         (rom_bhe),
    .rom_ble         (rom_ble),
    .snes_data_out   (snes_data_out),
    .snes_databus_oe (snes_databus_oe)
  );

endmodule

/* cart_vectors.txt */
# op    addr   data exp  (hex, mw data 00 takes an LFSR byte)
# mw exp is cycles until the CPU clock restarts, 00 none; read exp 100 uses the shadow image
alive   000000 00 000
mr      000000 00 03c
mr      000001 00 0c5
mw      000010 a7 000
mr      000010 00 0a7
mw      000011 5c 000
mr      000011 00 05c
mr      000010 00 0a7
mw      000020 00 000
mr      000020 00 100
mw      000035 00 000
mr      000035 00 100
mr      000034 00 026
mw      0001fe 3d 000
mw      0001ff c2 000
mr      0001fe 00 03d
mr      0001ff 00 0c2
alive   000000 01 000
sr      c00002 00 03d
sr      c00010 00 0a7
sr      c00011 00 05c
sr      c01234 00 100
sr      8081fe 00 03d
mr      000035 00 100
sr      c00035 00 100
mr      000011 00 05c
sr      c00011 00 05c
mw      000041 e6 000
sr      c00041 00 0e6
mr      000041 00 0e6
sr      c00040 00 01c
alive   000000 00 000
mw      000050 00 002
mr      000050 00 100
sr      c00050 00 100
mw      000061 00 000
sr      c00061 00 100
mr      000060 00 00c

/* rom_arbiter.sv */
`timescale 1ns/1ns
module rom_arbiter
  import snes_pkg::*;
  import rom_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,
  input  logic       free_slot,
  input  logic       snes_dead,
  input  logic       snes_revive,
  input  rom_addr_t  mcu_addr,
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  rom_word_t  rom_data_in,
  output rom_addr_t  mcu_rom_addr,
  output logic       mcu_rd_hit,
  output logic       mcu_wr_hit,
  output snes_byte_t mcu_din,
  output logic       mcu_rdy
);

  arb_state_t state;
  rom_delay_t mem_delay;
  logic       rd_pend;
  logic       wr_pend;
  rom_addr_t  addr_q;
  logic       access_end;

  assign access_end = (state == st_mcu_rd_end) || (state == st_mcu_wr_end);

  //////////////////////////////////////////////////////////////
  // MCU request capture
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) addr_q <= mcu_addr;
  end

  assign mcu_rom_addr = addr_q;

  //////////////////////////////////////////////////////////////
  // ROM access FSM
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state     <= st_idle;
      mem_delay <= '0;
    end else if (snes_revive) begin
      state <= st_idle;   // Pending flag restarts the access once the console is back
    end else begin
      case (state)
        st_idle: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state     <= st_mcu_rd_addr;
              mem_delay <= rom_cycle_len;
            end else if (wr_pend) begin
              state     <= st_mcu_wr_addr;
              mem_delay <= rom_cycle_len;
            end
          end
        end
        st_mcu_rd_addr: begin
          mem_delay <= mem_delay - rom_delay_t'(1);
          if (mem_delay == '0) state <= st_mcu_rd_end;
        end
        st_mcu_wr_addr: begin
          mem_delay <= mem_delay - rom_delay_t'(1);
          if (mem_delay == '0) state <= st_mcu_wr_end;
        end
        st_mcu_rd_end, st_mcu_wr_end: begin
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign mcu_rd_hit = (state == st_mcu_rd_addr);
  assign mcu_wr_hit = (state == st_mcu_wr_addr);

  // Read data follows the ROM for the whole address phase
  always_ff @(posedge CLK2) begin
    if (mcu_rd_hit) begin
      mcu_din <= addr_q[0] ? rom_data_in[7:0] : rom_data_in[15:8];   // Odd byte is low lane
    end
  end

  //////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////

  // Only one MCU request may wait for the ROM
  assert property (@(posedge CLK2) disable iff (reset) !(rd_pend && wr_pend))
    else $error("MCU read and write pending at once");

  // MCU must not see ready while the ROM bus is in use
  assert property (@(posedge CLK2) disable iff (reset) (state != st_idle) |-> !mcu_rdy)
    else $error("mcu_rdy high during ROM access");

endmodule

/* rom_pkg.sv */
package rom_pkg;

  ////////////////////////////////////////////////////////////
  // ROM bus types
  ////////////////////////////////////////////////////////////

  // Byte address, the word address is bits [23:1]
  typedef logic [23:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;   // High lane [15:8], low lane [7:0]
  typedef logic [4:0]  rom_delay_t;

  ////////////////////////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    st_idle,
    st_mcu_rd_addr,
    st_mcu_rd_end,
    st_mcu_wr_addr,
    st_mcu_wr_end
  } arb_state_t;

  // Countdown start, address phase lasts one clock longer
  localparam rom_delay_t rom_cycle_len = 5'd6;

endpackage

/* rom_port.sv */
`timescale 1ns/1ns
module rom_port
  import snes_pkg::*;
  import rom_pkg::*;
(
  input  logic        mcu_rd_hit,
  input  logic        mcu_wr_hit,
  input  rom_addr_t   mcu_rom_addr,
  input  snes_addr_t  snes_addr,
  input  rom_addr_t   rom_mask,
  input  logic        rom_hit,
  input  logic        snes_read,
  input  snes_byte_t  mcu_dout,
  input  rom_word_t   rom_data_in,
  output logic [22:0] rom_addr,
  output rom_word_t   rom_data_out,
  output logic        rom_data_oe,
  output logic        rom_we,
  output logic        rom_bhe,
  output logic        rom_ble,
  output snes_byte_t  snes_data_out,
  output logic        snes_databus_oe
);

  logic      mcu_hit;
  rom_addr_t snes_rom_addr;
  rom_addr_t sel_addr;
  logic      lane_lo;

  //////////////////////////////////////////////////////////////
  // Address select
  //////////////////////////////////////////////////////////////

  assign mcu_hit       = mcu_rd_hit | mcu_wr_hit;
  assign snes_rom_addr = rom_addr_t'(snes_addr) & rom_mask;   // Mirror into loaded image
  assign sel_addr      = mcu_hit ? mcu_rom_addr : snes_rom_addr;

  assign rom_addr = sel_addr[23:1];
  assign lane_lo  = sel_addr[0];

  // Active low lane enables
  assign rom_bhe = lane_lo;
  assign rom_ble = ~lane_lo;

  //////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////

  assign rom_data_out = lane_lo ? {8'h00, mcu_dout} : {mcu_dout, 8'h00};
  assign rom_data_oe  = mcu_wr_hit;
  assign rom_we       = ~mcu_wr_hit;   // Only the MCU writes ROM

  //////////////////////////////////////////////////////////////
  // SNES read return
  //////////////////////////////////////////////////////////////

  assign snes_data_out   = lane_lo ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_databus_oe = ~(rom_hit & ~snes_read);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the cart_main testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_cart_main \
  -f cart_main.f \
  -o tb_cart_main

./obj_dir/tb_cart_main

/* snes_bus_decode.sv */
`timescale 1ns/1ns
module snes_bus_decode
  import snes_pkg::*;
#(
  parameter int dead_timeout = 80000   // 1 ms of CLK2 cycles
) (
  input  logic       CLK2,
  input  logic       reset,
  input  snes_addr_t snes_addr_in,
  input  logic       snes_read_in,
  input  logic       snes_romsel_in,
  input  logic       snes_cpu_clk_in,
  output snes_addr_t snes_addr,
  output logic       snes_read,
  output logic       rom_hit,
  output logic       cycle_start,
  output logic       cycle_end,
  output logic       free_slot,
  output logic       snes_dead,
  output logic       snes_revive
);

  edge_hist_t    read_r;
  edge_hist_t    romsel_r;
  edge_hist_t    cpu_clk_r;
  snes_addr_t    addr_r [addr_stages];
  logic          free_strobe;
  snes_timeout_t dead_cnt;

  //////////////////////////////////////////////////////////////
  // Input sampling
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_r    <= '1;   // Bus idle
      romsel_r  <= '1;
      cpu_clk_r <= '0;
    end else begin
      read_r    <= {read_r[6:0], snes_read_in};
      romsel_r  <= {romsel_r[6:0], snes_romsel_in};
      cpu_clk_r <= {cpu_clk_r[6:0], snes_cpu_clk_in};
    end
  end

  // Address delayed to line up with the filtered strobes
  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    for (int i = 1; i < addr_stages; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  assign snes_addr = addr_r[addr_stages-1];

  // Two-sample glitch filter on the levels
  assign snes_read = read_r[2] & read_r[1];
  assign rom_hit   = ~(romsel_r[5] & romsel_r[4]);   // Aligned closer to the address

  assign cycle_start = ((cpu_clk_r[7:2] & cpu_clk_r[6:1]) == cycle_start_pat);
  assign cycle_end   = ((cpu_clk_r[7:2] | cpu_clk_r[6:1]) == cycle_end_pat);

  //////////////////////////////////////////////////////////////
  // Free bus slots
  //////////////////////////////////////////////////////////////

  // Cycle that started without touching ROM leaves the bus to the MCU
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  //////////////////////////////////////////////////////////////
  // Dead SNES detection
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
    end else if (cpu_clk_r[1]) begin
      dead_cnt <= '0;
    end else if (dead_cnt != '1) begin   // Hold at top
      dead_cnt <= dead_cnt + snes_timeout_t'(1);
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_dead   <= 1'b1;   // Assume no console until a clock shows up
      snes_revive <= 1'b0;
    end else begin
      snes_revive <= 1'b0;
      if (cpu_clk_r[1]) begin
        snes_dead <= 1'b0;
        if (snes_dead) snes_revive <= 1'b1;   // First clock after a dead period
      end else if (dead_cnt > snes_timeout_t'(dead_timeout)) begin
        snes_dead <= 1'b1;
      end
    end
  end

  // Revival only on a rising CPU clock so it never lasts two cycles
  assert property (@(posedge CLK2) disable iff (reset)
                   snes_revive |-> $past(cpu_clk_r[1] & ~cpu_clk_r[2]))
    else $error("snes_revive without a rising CPU clock");

endmodule

/* snes_pkg.sv */
package snes_pkg;

  ////////////////////////////////////////////////////////////
  // SNES bus types
  ////////////////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;   // CPU address, bank in [23:16]
  typedef logic [7:0]  snes_byte_t;   // One data bus byte
  typedef logic [7:0]  edge_hist_t;   // Newest sample in bit 0
  typedef logic [17:0] snes_timeout_t;

  ////////////////////////////////////////////////////////////
  // Sampling
  ////////////////////////////////////////////////////////////

  // Address pipeline depth, output taken from the last stage
  localparam int addr_stages = 7;

  // CPU clock window patterns over history bits [7:2] and [6:1]
  // Rising clock seen through AND of neighbouring samples
  localparam logic [5:0] cycle_start_pat = 6'b000011;
  // Falling clock seen through OR of neighbouring samples
  localparam logic [5:0] cycle_end_pat   = 6'b111000;

endpackage

/* tb_cart_main.sv */
`timescale 1ns/1ns
module tb_cart_main
  import snes_pkg::*;
  import rom_pkg::*;
();

  localparam int        dead_timeout = 200;
  localparam rom_addr_t image_mask   = 24'h0001ff;   // 512-byte ROM image
  localparam int        op_mw        = 0;
  localparam int        op_mr        = 1;
  localparam int        op_sr        = 2;
  localparam int        op_alive     = 3;

  logic        CLK2 = 1'b0;
  logic        reset;
  snes_addr_t  snes_addr_in;
  logic        snes_read_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in = 1'b0;
  snes_byte_t  snes_data_out;
  logic        snes_databus_oe;
  rom_addr_t   rom_mask;
  rom_addr_t   mcu_addr;
  logic        mcu_rrq;
  logic        mcu_wrq;
  snes_byte_t  mcu_dout;
  snes_byte_t  mcu_din;
  logic        mcu_rdy;
  logic [22:0] rom_addr;
  rom_word_t   rom_data_out;
  logic        rom_data_oe;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  rom_word_t   rom_data_in;

  rom_word_t   rom_mem [256];
  snes_byte_t  shadow [512];   // Expected image by byte address
  logic [15:0] lfsr;
  logic        cpu_run;
  logic        run_s;
  logic [2:0]  cpu_phase = 3'd5;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          vec_op[$];
  logic [23:0] vec_addr[$];
  snes_byte_t  vec_data[$];
  logic [8:0]  vec_exp[$];

  always #4 CLK2 = ~CLK2;

  cart_main #(
    .dead_timeout (dead_timeout)
  ) u_dut (
    .CLK2            (CLK2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_data_out   (snes_data_out),
    .snes_databus_oe (snes_databus_oe),
    .rom_mask        (rom_mask),
    .mcu_addr        (mcu_addr),
    .mcu_rrq         (mcu_rrq),
    .mcu_wrq         (mcu_wrq),
    .mcu_dout        (mcu_dout),
    .mcu_din         (mcu_din),
    .mcu_rdy         (mcu_rdy),
    .rom_addr        (rom_addr),
    .rom_data_out    (rom_data_out),
    .rom_data_oe     (rom_data_oe),
    .rom_we          (rom_we),
    .rom_bhe         (rom_bhe),
    .rom_ble         (rom_ble),
    .rom_data_in     (rom_data_in)
  );

  ////////////////////////////////////////////////////////////
  // ROM and SNES models
  ////////////////////////////////////////////////////////////

  function automatic rom_word_t fill_word(input logic [7:0] i);
    return {i ^ 8'h3c, {i[3:0], i[7:4]} ^ 8'hc5};
  endfunction

  assign rom_data_in = rom_mem[rom_addr[7:0]];

  always @(posedge CLK2) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        rom_mem[8'(i)] <= fill_word(8'(i));
      end
    end else if (!rom_we && rom_data_oe) begin
      // Lane enables are active low
      if (!rom_bhe) rom_mem[rom_addr[7:0]][15:8] <= rom_data_out[15:8];
      if (!rom_ble) rom_mem[rom_addr[7:0]][7:0] <= rom_data_out[7:0];
    end else if (rom_data_oe) begin
      $display("ROM data bus driven at %0t while the ROM is not written", $time);
      $display("RESULT: FAIL");
      $fatal(1, "ROM bus conflict");
    end
  end

  // CPU clock of 12 CLK2 cycles per period that starts high
  always @(posedge CLK2) begin
    run_s = cpu_run;
    #1;
    if (!run_s) begin
      cpu_phase = 3'd5;
      snes_cpu_clk_in = 1'b0;
    end else if (cpu_phase == 3'd5) begin
      cpu_phase = 3'd0;
      snes_cpu_clk_in = ~snes_cpu_clk_in;
    end else begin
      cpu_phase = cpu_phase + 3'd1;
    end
  end

  always @(posedge CLK2) begin
    if (cycle_limit > 0) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        $display("Timeout after %0d cycles, the DUT never finished the vectors", cycle_limit);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_byte(input snes_byte_t got, input snes_byte_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %02h, expected %02h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "byte mismatch");
    end
  endtask

  task automatic check_addr(input rom_addr_t got, input rom_addr_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %06h, expected %06h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic lfsr_byte(output snes_byte_t b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr[15]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic int decode_op(input logic [39:0] t);
    case (t)
      40'("mw"):    return op_mw;
      40'("mr"):    return op_mr;
      40'("sr"):    return op_sr;
      40'("alive"): return op_alive;
      default:      return -1;
    endcase
  endfunction

  task automatic wait_ready();
    while (!mcu_rdy) begin
      @(posedge CLK2);
      #1;
    end
  endtask

  // One request pulse after which rdy must drop
  task automatic mcu_request(input rom_addr_t a, input logic wr);
    mcu_addr = a;
    mcu_wrq = wr;
    mcu_rrq = ~wr;
    @(posedge CLK2);
    #1;
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    check_bit(mcu_rdy, 1'b0, "mcu_rdy after request");
  endtask

  task automatic mcu_write(input rom_addr_t a, input snes_byte_t d, input int revive_after);
    snes_byte_t other;
    rom_word_t  word;
    other = shadow[{a[8:1], ~a[0]}];
    mcu_dout = d;
    mcu_request(a, 1'b1);
    if (revive_after > 0) begin
      repeat (revive_after) @(posedge CLK2);
      #1;
      cpu_run = 1'b1;   // Console wakes up mid access
    end
    wait_ready();
    shadow[a[8:0]] = d;
    word = rom_mem[a[8:1]];
    // Odd byte lives in the low lane
    check_byte(a[0] ? word[7:0] : word[15:8], d, "written ROM lane");
    check_byte(a[0] ? word[15:8] : word[7:0], other, "untouched ROM lane");
  endtask

  task automatic mcu_read(input rom_addr_t a, input logic [8:0] exp_field);
    snes_byte_t exp;
    exp = (exp_field == 9'h100) ? shadow[a[8:0]] : exp_field[7:0];
    mcu_request(a, 1'b0);
    wait_ready();
    check_byte(mcu_din, exp, "mcu_din");
  endtask

  task automatic snes_rom_read(input snes_addr_t a, input logic [8:0] exp_field);
    rom_addr_t  masked;
    snes_byte_t exp;
    masked = rom_addr_t'(a) & image_mask;
    exp = (exp_field == 9'h100) ? shadow[masked[8:0]] : exp_field[7:0];
    snes_addr_in = a;
    snes_romsel_in = 1'b0;
    repeat (2) @(posedge CLK2);
    #1;
    snes_read_in = 1'b0;
    repeat (11) @(posedge CLK2);   // Last of 12 read cycles
    #1;
    check_bit(snes_databus_oe, 1'b0, "snes_databus_oe");
    check_addr({rom_addr, rom_bhe}, masked, "ROM byte address");
    check_byte(snes_data_out, exp, "snes_data_out");
    @(posedge CLK2);
    #1;
    snes_read_in = 1'b1;
  endtask

  task automatic set_alive(input logic run);
    cpu_run = run;
    repeat (run ? 24 : dead_timeout + 20) @(posedge CLK2);
    #1;
  endtask

  initial begin
    int          fd;
    int          code;
    int          op;
    string       line;
    logic [39:0] op_txt;
    logic [23:0] f_addr;
    snes_byte_t  f_data;
    logic [8:0]  f_exp;
    snes_byte_t  data;
    rom_word_t   w;

    reset          = 1'b1;
    snes_addr_in   = '0;
    snes_read_in   = 1'b1;
    snes_romsel_in = 1'b1;
    rom_mask       = image_mask;
    mcu_addr       = '0;
    mcu_rrq        = 1'b0;
    mcu_wrq        = 1'b0;
    mcu_dout       = '0;
    cpu_run        = 1'b0;
    lfsr           = 16'd81;
    for (int i = 0; i < 256; i++) begin
      w = fill_word(8'(i));
      shadow[{8'(i), 1'b0}] = w[15:8];
      shadow[{8'(i), 1'b1}] = w[7:0];
    end

    fd = $fopen("cart_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open cart_vectors.txt");
      $display("RESULT: FAIL");
      $fatal(1, "missing vector file");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%s %h %h %h", op_txt, f_addr, f_data, f_exp);
        op = decode_op(op_txt);
        if (code != 4 || op < 0) begin
          $display("Bad line in cart_vectors.txt: %s", line);
          $display("RESULT: FAIL");
          $fatal(1, "bad vector line");
        end
        vec_op.push_back(op);
        vec_addr.push_back(f_addr);
        vec_data.push_back(f_data);
        vec_exp.push_back(f_exp);
      end
    end
    $fclose(fd);
    cycle_limit = 60 * vec_op.size() + 500;

    repeat (8) @(posedge CLK2);
    #1;
    reset = 1'b0;
    check_bit(mcu_rdy, 1'b1, "mcu_rdy after reset");
    check_bit(rom_we, 1'b1, "rom_we after reset");
    check_bit(snes_databus_oe, 1'b1, "snes_databus_oe after reset");
    check_bit(rom_data_oe, 1'b0, "rom_data_oe after reset");

    for (int v = 0; v < vec_op.size(); v++) begin
      case (vec_op[v])
        op_mw: begin
          data = vec_data[v];
          if (data == 8'h00) lfsr_byte(data);
          mcu_write(vec_addr[v], data, int'(vec_exp[v]));
        end
        op_mr:   mcu_read(vec_addr[v], vec_exp[v]);
        op_sr:   snes_rom_read(vec_addr[v], vec_exp[v]);
        default: set_alive(vec_data[v][0]);
      endcase
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule
